// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = backend_tb
FILELIST  = project.f
SRCS      = $(shell grep -v '^+' $(FILELIST))
BIN       = obj_dir/V$(TOP)
LOG       = sim.log

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: hdl/alu.sv
`timescale 1ns/10ps

module alu (
    input  cpu_pkg::alu_op_t            alu_op,
    input  logic [cpu_pkg::data_w-1:0]  alu_src1,
    input  logic [cpu_pkg::data_w-1:0]  alu_src2,
    output logic [cpu_pkg::data_w-1:0]  alu_result
);
    import cpu_pkg::*;

    logic              adder_sub;
    logic [data_w-1:0] adder_b;
    logic [data_w-1:0] adder_sum;
    logic              adder_cout;
    logic              slt_bit;
    logic              sltu_bit;
    logic [data_w-1:0] sll_result;
    logic [data_w-1:0] srl_result;
    logic [data_w-1:0] sra_result;
    logic [data_w-1:0] lui_result;

    // one shared adder that subtracts by inverting src2 and carrying in
    assign adder_sub = alu_op.sub | alu_op.slt | alu_op.sltu;
    assign adder_b   = adder_sub ? ~alu_src2 : alu_src2;
    assign {adder_cout, adder_sum} = {1'b0, alu_src1} + {1'b0, adder_b}
                                   + {{data_w{1'b0}}, adder_sub};

    // signed compare from the sign bits and the difference
    assign slt_bit  = (alu_src1[data_w-1] & ~alu_src2[data_w-1])
                    | (~(alu_src1[data_w-1] ^ alu_src2[data_w-1]) & adder_sum[data_w-1]);
    // no carry out of the subtract means a borrow
    assign sltu_bit = ~adder_cout;

    // shift amount from src1 and value from src2
    assign sll_result = alu_src2 << alu_src1[4:0];
    assign srl_result = alu_src2 >> alu_src1[4:0];
    assign sra_result = $signed(alu_src2) >>> alu_src1[4:0];
    assign lui_result = {alu_src2[15:0], 16'b0};

    assign alu_result = ({data_w{alu_op.add | alu_op.sub}} & adder_sum)
                      | ({data_w{alu_op.slt}}  & {{(data_w-1){1'b0}}, slt_bit})
                      | ({data_w{alu_op.sltu}} & {{(data_w-1){1'b0}}, sltu_bit})
                      | ({data_w{alu_op.op_and}} & (alu_src1 & alu_src2))
                      | ({data_w{alu_op.op_nor}} & ~(alu_src1 | alu_src2))
                      | ({data_w{alu_op.op_or}}  & (alu_src1 | alu_src2))
                      | ({data_w{alu_op.op_xor}} & (alu_src1 ^ alu_src2))
                      | ({data_w{alu_op.sll}} & sll_result)
                      | ({data_w{alu_op.srl}} & srl_result)
                      | ({data_w{alu_op.sra}} & sra_result)
                      | ({data_w{alu_op.lui}} & lui_result);

endmodule

// File: hdl/backend_top.sv
`timescale 1ns/10ps

module backend_top #(
    parameter int unsigned data_ram_words = 1024
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               ds_to_es_valid,
    input  cpu_pkg::ds_to_es_t ds_to_es_bus,
    output cpu_pkg::wb_t       wb
);
    import cpu_pkg::*;

    logic              es_to_ms_valid;
    es_to_ms_t         es_to_ms_bus;
    logic              ms_to_ws_valid;
    ms_to_ws_t         ms_to_ws_bus;
    fwd_src_t          ms_fwd;
    fwd_src_t          ws_fwd;
    logic              data_sram_en;
    logic              data_sram_we;
    logic [data_w-1:0] data_sram_addr;
    logic [data_w-1:0] data_sram_wdata;
    logic [data_w-1:0] data_sram_rdata;

    exe_stage u_exe_stage (
        .clk             (clk),
        .reset           (reset),
        .ds_to_es_valid  (ds_to_es_valid),
        .ds_to_es_bus    (ds_to_es_bus),
        .ms_fwd          (ms_fwd),
        .ws_fwd          (ws_fwd),
        .es_to_ms_valid  (es_to_ms_valid),
        .es_to_ms_bus    (es_to_ms_bus),
        .data_sram_en    (data_sram_en),
        .data_sram_we    (data_sram_we),
        .data_sram_addr  (data_sram_addr),
        .data_sram_wdata (data_sram_wdata)
    );

    // read data lands while the access is in the memory stage
    data_ram #(
        .data_ram_words (data_ram_words)
    ) u_data_ram (
        .clk   (clk),
        .en    (data_sram_en),
        .we    (data_sram_we),
        .addr  (data_sram_addr),
        .wdata (data_sram_wdata),
        .rdata (data_sram_rdata)
    );

    mem_stage u_mem_stage (
        .clk             (clk),
        .reset           (reset),
        .es_to_ms_valid  (es_to_ms_valid),
        .es_to_ms_bus    (es_to_ms_bus),
        .data_sram_rdata (data_sram_rdata),
        .ms_to_ws_valid  (ms_to_ws_valid),
        .ms_to_ws_bus    (ms_to_ws_bus),
        .ms_fwd          (ms_fwd)
    );

    wb_stage u_wb_stage (
        .clk            (clk),
        .reset          (reset),
        .ms_to_ws_valid (ms_to_ws_valid),
        .ms_to_ws_bus   (ms_to_ws_bus),
        .wb             (wb),
        .ws_fwd         (ws_fwd)
    );

endmodule

// File: hdl/cpu_pkg.sv
package cpu_pkg;

    localparam int unsigned data_w     = 32;
    localparam int unsigned reg_addr_w = 5;
    localparam int unsigned imm_w      = 16;

    // one-hot ALU operation with add in bit 0 and lui in bit 11
    typedef struct packed {
        logic lui;
        logic sra;
        logic srl;
        logic sll;
        logic op_xor;
        logic op_or;
        logic op_nor;
        logic op_and;
        logic sltu;
        logic slt;
        logic sub;
        logic add;
    } alu_op_t;

    // operand source picked by the forwarding unit
    typedef enum logic [1:0] {
        fwd_reg = 2'd0,
        fwd_mem = 2'd1,
        fwd_wb  = 2'd2
    } fwd_sel_t;

    typedef struct packed {
        alu_op_t                alu_op;
        logic                   load_op;
        logic                   src1_is_sa;
        logic                   src1_is_pc;
        logic                   src2_is_imm;
        logic                   src2_is_8;
        logic                   gr_we;
        logic                   mem_we;
        logic [reg_addr_w-1:0]  dest;
        logic [reg_addr_w-1:0]  rs_addr;
        logic [reg_addr_w-1:0]  rt_addr;
        logic [imm_w-1:0]       imm;
        logic [data_w-1:0]      rs_value;
        logic [data_w-1:0]      rt_value;
        logic [data_w-1:0]      pc;
    } ds_to_es_t;

    typedef struct packed {
        logic                   res_from_mem;
        logic                   gr_we;
        logic [reg_addr_w-1:0]  dest;
        logic [data_w-1:0]      alu_result;
        logic [data_w-1:0]      pc;
    } es_to_ms_t;

    typedef struct packed {
        logic                   gr_we;
        logic [reg_addr_w-1:0]  dest;
        logic [data_w-1:0]      final_result;
        logic [data_w-1:0]      pc;
    } ms_to_ws_t;

    typedef struct packed {
        logic                   rf_we;
        logic [reg_addr_w-1:0]  dest;
        logic [data_w-1:0]      wdata;
        logic [data_w-1:0]      pc;
    } wb_t;

    // one forwarding source as driven by the memory and writeback stages
    typedef struct packed {
        logic                   valid;
        logic                   gr_we;
        logic [reg_addr_w-1:0]  dest;
        logic [data_w-1:0]      value;
    } fwd_src_t;

endpackage

// File: hdl/data_ram.sv
`timescale 1ns/10ps

module data_ram #(
    parameter int unsigned data_ram_words = 1024
) (
    input  logic        clk,
    input  logic        en,
    input  logic        we,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    output logic [31:0] rdata
);

    logic [31:0] mem [data_ram_words];
    logic [31:0] word_idx;

    // word address wrapped to the array depth
    assign word_idx = addr[31:2] % data_ram_words;

    // read returns the old word on a write to the same address
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[word_idx] <= wdata;
            end
            rdata <= mem[word_idx];
        end
    end

endmodule

// File: hdl/exe_stage.sv
`timescale 1ns/10ps

module exe_stage (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           ds_to_es_valid,
    input  cpu_pkg::ds_to_es_t             ds_to_es_bus,
    input  cpu_pkg::fwd_src_t              ms_fwd,
    input  cpu_pkg::fwd_src_t              ws_fwd,
    output logic                           es_to_ms_valid,
    output cpu_pkg::es_to_ms_t             es_to_ms_bus,
    output logic                           data_sram_en,
    output logic                           data_sram_we,
    output logic [cpu_pkg::data_w-1:0]     data_sram_addr,
    output logic [cpu_pkg::data_w-1:0]     data_sram_wdata
);
    import cpu_pkg::*;

    logic              es_valid;
    ds_to_es_t         es_bus_r;
    fwd_sel_t          src1_sel;
    fwd_sel_t          src2_sel;
    logic [data_w-1:0] rs_fwd_value;
    logic [data_w-1:0] rt_fwd_value;
    logic [data_w-1:0] alu_src1;
    logic [data_w-1:0] alu_src2;
    logic [data_w-1:0] alu_result;

    always_ff @(posedge clk) begin
        if (reset) begin
            es_valid <= 1'b0;
        end else begin
            es_valid <= ds_to_es_valid;
        end
    end

    // instruction payload qualified by es_valid
    always_ff @(posedge clk) begin
        if (ds_to_es_valid) begin
            es_bus_r <= ds_to_es_bus;
        end
    end

    forward_unit u_forward_unit (
        .rs_addr  (es_bus_r.rs_addr),
        .rt_addr  (es_bus_r.rt_addr),
        .ms_fwd   (ms_fwd),
        .ws_fwd   (ws_fwd),
        .src1_sel (src1_sel),
        .src2_sel (src2_sel)
    );

    // register values patched with in-flight results
    assign rs_fwd_value = (src1_sel == fwd_mem) ? ms_fwd.value :
                          (src1_sel == fwd_wb)  ? ws_fwd.value :
                                                  es_bus_r.rs_value;
    assign rt_fwd_value = (src2_sel == fwd_mem) ? ms_fwd.value :
                          (src2_sel == fwd_wb)  ? ws_fwd.value :
                                                  es_bus_r.rt_value;

    // shift amount lives in imm[10:6]
    assign alu_src1 = es_bus_r.src1_is_sa ? {27'b0, es_bus_r.imm[10:6]} :
                      es_bus_r.src1_is_pc ? es_bus_r.pc :
                                            rs_fwd_value;
    assign alu_src2 = es_bus_r.src2_is_imm ? {{16{es_bus_r.imm[15]}}, es_bus_r.imm} :
                      es_bus_r.src2_is_8   ? 32'd8 :
                                             rt_fwd_value;

    alu u_alu (
        .alu_op     (es_bus_r.alu_op),
        .alu_src1   (alu_src1),
        .alu_src2   (alu_src2),
        .alu_result (alu_result)
    );

    // store data also goes through forwarding
    assign data_sram_en    = es_valid;
    assign data_sram_we    = es_valid & es_bus_r.mem_we;
    assign data_sram_addr  = alu_result;
    assign data_sram_wdata = rt_fwd_value;

    assign es_to_ms_valid = es_valid;
    assign es_to_ms_bus   = '{res_from_mem: es_bus_r.load_op,
                              gr_we:        es_bus_r.gr_we,
                              dest:         es_bus_r.dest,
                              alu_result:   alu_result,
                              pc:           es_bus_r.pc};

endmodule

// File: hdl/forward_unit.sv
`timescale 1ns/10ps

module forward_unit (
    input  logic [cpu_pkg::reg_addr_w-1:0] rs_addr,
    input  logic [cpu_pkg::reg_addr_w-1:0] rt_addr,
    input  cpu_pkg::fwd_src_t              ms_fwd,
    input  cpu_pkg::fwd_src_t              ws_fwd,
    output cpu_pkg::fwd_sel_t              src1_sel,
    output cpu_pkg::fwd_sel_t              src2_sel
);
    import cpu_pkg::*;

    // a stage can supply src if it writes a nonzero register equal to src
    function automatic logic hits(input fwd_src_t fwd, input logic [reg_addr_w-1:0] src);
        return fwd.valid && fwd.gr_we && (fwd.dest != '0) && (fwd.dest == src);
    endfunction

    // memory is the younger result, so it has priority over writeback
    function automatic fwd_sel_t pick(input logic [reg_addr_w-1:0] src,
                                      input fwd_src_t ms,
                                      input fwd_src_t ws);
        fwd_sel_t sel;
        sel = fwd_reg;
        if (hits(ms, src)) begin
            sel = fwd_mem;
        end else if (hits(ws, src)) begin
            sel = fwd_wb;
        end
        return sel;
    endfunction

    assign src1_sel = pick(rs_addr, ms_fwd, ws_fwd);
    assign src2_sel = pick(rt_addr, ms_fwd, ws_fwd);

endmodule

// File: hdl/mem_stage.sv
`timescale 1ns/10ps

module mem_stage (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       es_to_ms_valid,
    input  cpu_pkg::es_to_ms_t         es_to_ms_bus,
    input  logic [cpu_pkg::data_w-1:0] data_sram_rdata,
    output logic                       ms_to_ws_valid,
    output cpu_pkg::ms_to_ws_t         ms_to_ws_bus,
    output cpu_pkg::fwd_src_t          ms_fwd
);
    import cpu_pkg::*;

    logic              ms_valid;
    es_to_ms_t         ms_bus_r;
    logic [data_w-1:0] final_result;

    always_ff @(posedge clk) begin
        if (reset) begin
            ms_valid <= 1'b0;
        end else begin
            ms_valid <= es_to_ms_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (es_to_ms_valid) begin
            ms_bus_r <= es_to_ms_bus;
        end
    end

    // load data comes straight off the ram output register
    assign final_result = ms_bus_r.res_from_mem ? data_sram_rdata : ms_bus_r.alu_result;

    assign ms_to_ws_valid = ms_valid;
    assign ms_to_ws_bus   = '{gr_we:        ms_bus_r.gr_we,
                              dest:         ms_bus_r.dest,
                              final_result: final_result,
                              pc:           ms_bus_r.pc};

    assign ms_fwd = '{valid: ms_valid,
                      gr_we: ms_bus_r.gr_we,
                      dest:  ms_bus_r.dest,
                      value: final_result};

endmodule

// File: hdl/wb_stage.sv
`timescale 1ns/10ps

module wb_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               ms_to_ws_valid,
    input  cpu_pkg::ms_to_ws_t ms_to_ws_bus,
    output cpu_pkg::wb_t       wb,
    output cpu_pkg::fwd_src_t  ws_fwd
);
    import cpu_pkg::*;

    logic      ws_valid;
    ms_to_ws_t ws_bus_r;

    always_ff @(posedge clk) begin
        if (reset) begin
            ws_valid <= 1'b0;
        end else begin
            ws_valid <= ms_to_ws_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ms_to_ws_valid) begin
            ws_bus_r <= ms_to_ws_bus;
        end
    end

    // writes to r0 are dropped here
    assign wb = '{rf_we: ws_valid & ws_bus_r.gr_we & (ws_bus_r.dest != '0),
                  dest:  ws_bus_r.dest,
                  wdata: ws_bus_r.final_result,
                  pc:    ws_bus_r.pc};

    assign ws_fwd = '{valid: ws_valid,
                      gr_we: ws_bus_r.gr_we,
                      dest:  ws_bus_r.dest,
                      value: ws_bus_r.final_result};

endmodule

// File: project.f
hdl/cpu_pkg.sv
hdl/alu.sv
hdl/forward_unit.sv
hdl/exe_stage.sv
hdl/data_ram.sv
hdl/mem_stage.sv
hdl/wb_stage.sv
hdl/backend_top.sv
verif/backend_tb.sv

// File: verif/backend_tb.sv
`timescale 1ns/10ps

module backend_tb;
    import cpu_pkg::*;

    localparam int ram_words    = 1024;
    localparam int num_instrs   = 300;
    localparam int slack_cycles = 200;

    logic      clk;
    logic      reset;
    logic      ds_to_es_valid;
    ds_to_es_t ds_to_es_bus;
    wb_t       wb;

    // architectural model updated in program order at issue
    logic [31:0] arch [32];
    logic [31:0] mem_model [int];
    // register file as decode sees it and written by wb pulses only
    logic [31:0] shadow [32];

    wb_t         exp_q [$];
    int          cyc_q [$];
    int          cycle;
    int          errors;
    int          tests_run;
    int          tests_failed;
    logic [31:0] pc_next;

    backend_top #(
        .data_ram_words (ram_words)
    ) uut (
        .clk            (clk),
        .reset          (reset),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es_bus   (ds_to_es_bus),
        .wb             (wb)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic logic [31:0] ref_alu(input alu_op_t op, input logic [31:0] a,
                                            input logic [31:0] b);
        logic [31:0] r;
        r = '0;
        case (1'b1)
            op.add:    r = a + b;
            op.sub:    r = a - b;
            op.slt:    r = {31'b0, $signed(a) < $signed(b)};
            op.sltu:   r = {31'b0, a < b};
            op.op_and: r = a & b;
            op.op_nor: r = ~(a | b);
            op.op_or:  r = a | b;
            op.op_xor: r = a ^ b;
            op.sll:    r = b << a[4:0];
            op.srl:    r = b >> a[4:0];
            op.sra:    r = $signed(b) >>> a[4:0];
            op.lui:    r = {b[15:0], 16'h0000};
            default:   r = '0;
        endcase
        return r;
    endfunction

    // k selects the one-hot bit with add at 0 and lui at 11
    function automatic ds_to_es_t make_ins(input int k, input int dest, input int rs,
                                           input int rt, input int imm, input logic use_imm);
        ds_to_es_t ins;
        ins             = '0;
        ins.alu_op      = alu_op_t'(12'b1 << k);
        ins.gr_we       = 1'b1;
        ins.dest        = 5'(dest);
        ins.rs_addr     = 5'(rs);
        ins.rt_addr     = 5'(rt);
        ins.imm         = 16'(imm);
        ins.src2_is_imm = use_imm;
        return ins;
    endfunction

    task automatic compare_wb(input wb_t got, input wb_t exp);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: wb got r%0d=%h pc %h, expected r%0d=%h pc %h",
                     $time, got.dest, got.wdata, got.pc, exp.dest, exp.wdata, exp.pc);
        end
    endtask

    task automatic compare_latency(input int got, input int exp);
        if (got != exp) begin
            errors++;
            $display("MISMATCH at %0t: wb pulse cycle got %0d, expected %0d", $time, got, exp);
        end
    endtask

    // monitor runs just before the driver in each cycle
    always @(posedge clk) begin
        #1;
        if (!reset && wb.rf_we) begin
            shadow[wb.dest] = wb.wdata;
            if (exp_q.size() == 0) begin
                errors++;
                $display("%0t: writeback to r%0d arrived but none was expected", $time, wb.dest);
            end else begin
                compare_wb(wb, exp_q.pop_front());
                compare_latency(cycle, cyc_q.pop_front());
            end
        end
    end

    task automatic issue(input ds_to_es_t ins);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        int          idx;
        wb_t         exp;
        @(posedge clk);
        #2;
        ins.pc       = pc_next;
        pc_next      = pc_next + 4;
        ins.rs_value = shadow[ins.rs_addr];
        ins.rt_value = shadow[ins.rt_addr];
        a = ins.src1_is_sa ? {27'b0, ins.imm[10:6]} :
            ins.src1_is_pc ? ins.pc : arch[ins.rs_addr];
        b = ins.src2_is_imm ? {{16{ins.imm[15]}}, ins.imm} :
            ins.src2_is_8 ? 32'd8 : arch[ins.rt_addr];
        res = ref_alu(ins.alu_op, a, b);
        idx = int'(res[31:2] % ram_words);
        if (ins.mem_we) begin
            mem_model[idx] = arch[ins.rt_addr];
        end
        if (ins.load_op) begin
            if (!mem_model.exists(idx)) begin
                errors++;
                $display("%0t: load from word %0d that was never stored", $time, idx);
            end
            res = mem_model[idx];
        end
        if (ins.gr_we && ins.dest != 0) begin
            exp = '{rf_we: 1'b1, dest: ins.dest, wdata: res, pc: ins.pc};
            exp_q.push_back(exp);
            cyc_q.push_back(cycle + 3);
            arch[ins.dest] = res;
        end
        ds_to_es_valid = 1'b1;
        ds_to_es_bus   = ins;
    endtask

    task automatic gap(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
            ds_to_es_valid = 1'b0;
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        int waited;
        waited = 0;
        gap(1);
        while (exp_q.size() != 0 && waited < 6) begin
            @(posedge clk);
            #3;
            waited++;
        end
        // a couple more cycles so a stray pulse still gets caught
        gap(2);
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0t: %s ended with %0d writebacks that never arrived",
                     $time, name, exp_q.size());
            exp_q.delete();
            cyc_q.delete();
        end
        tests_run++;
        if (errors != errors_before) begin
            tests_failed++;
        end
        $display("%-12s %s (%0d errors)", name, (errors == errors_before) ? "ok" : "FAILED",
                 errors - errors_before);
    endtask

    task automatic alu_ops_test();
        ds_to_es_t ins;
        int        e0;
        e0 = errors;
        for (int r = 1; r <= 4; r++) begin
            issue(make_ins(11, r, 0, 0, $urandom(), 1'b1));
            issue(make_ins(6, r, r, 0, $urandom(), 1'b1));
        end
        gap(4);
        for (int k = 0; k < 12; k++) begin
            issue(make_ins(k, 8 + k, 1 + (k % 4), 1 + ((k + 1) % 4), 0, 1'b0));
        end
        issue(make_ins(0, 20, 3, 0, 'hfff0, 1'b1));
        ins = make_ins(8, 21, 0, 2, 7 << 6, 1'b0);
        ins.src1_is_sa = 1'b1;
        issue(ins);
        ins = make_ins(10, 22, 0, 1, 13 << 6, 1'b0);
        ins.src1_is_sa = 1'b1;
        issue(ins);
        // link address as pc plus 8
        ins = make_ins(0, 23, 0, 0, 0, 1'b0);
        ins.src1_is_pc = 1'b1;
        ins.src2_is_8  = 1'b1;
        issue(ins);
        issue(make_ins(11, 24, 0, 0, 'hbeef, 1'b1));
        issue(make_ins(2, 25, 4, 0, -3, 1'b1));
        finish_test("alu_ops", e0);
    endtask

    task automatic chain_test();
        int e0;
        int prev;
        e0   = errors;
        prev = 1;
        for (int i = 0; i < 8; i++) begin
            issue(make_ins(i, 5 + (i % 3), prev, (i % 2) ? prev : 2, 0, 1'b0));
            prev = 5 + (i % 3);
        end
        finish_test("chain", e0);
    endtask

    task automatic distance_test();
        int e0;
        e0 = errors;
        issue(make_ins(0, 8, 1, 0, 'h11, 1'b1));
        issue(make_ins(0, 9, 2, 3, 0, 1'b0));
        issue(make_ins(1, 10, 8, 1, 0, 1'b0));
        issue(make_ins(7, 11, 2, 8, 0, 1'b0));
        // both stages hold r12 and the younger value must win
        issue(make_ins(0, 12, 1, 0, 5, 1'b1));
        issue(make_ins(0, 12, 2, 0, 9, 1'b1));
        issue(make_ins(0, 13, 12, 12, 0, 1'b0));
        issue(make_ins(6, 14, 12, 13, 0, 1'b0));
        issue(make_ins(0, 15, 1, 0, 1, 1'b1));
        issue(make_ins(0, 16, 2, 0, 2, 1'b1));
        issue(make_ins(1, 17, 16, 15, 0, 1'b0));
        finish_test("distance", e0);
    endtask

    task automatic store(input int base, input int rt, input int offset);
        ds_to_es_t ins;
        ins        = make_ins(0, 0, base, rt, offset, 1'b1);
        ins.gr_we  = 1'b0;
        ins.mem_we = 1'b1;
        issue(ins);
    endtask

    task automatic load(input int dest, input int base, input int offset);
        ds_to_es_t ins;
        ins         = make_ins(0, dest, base, 0, offset, 1'b1);
        ins.load_op = 1'b1;
        issue(ins);
    endtask

    task automatic memory_test();
        int e0;
        e0 = errors;
        store(0, 1, 'h40);
        load(18, 0, 'h40);
        issue(make_ins(0, 19, 18, 18, 0, 1'b0));
        issue(make_ins(0, 20, 2, 0, 'h123, 1'b1));
        store(0, 20, 'h44);
        load(21, 0, 'h44);
        issue(make_ins(7, 22, 21, 20, 0, 1'b0));
        issue(make_ins(0, 23, 3, 0, 7, 1'b1));
        issue(make_ins(0, 24, 1, 1, 0, 1'b0));
        store(0, 23, 'h48);
        load(25, 0, 'h48);
        store(1, 2, 'h10);
        load(26, 1, 'h10);
        finish_test("memory", e0);
    endtask

    task automatic zero_reg_test();
        ds_to_es_t ins;
        int        e0;
        e0 = errors;
        issue(make_ins(0, 0, 1, 2, 0, 1'b0));
        issue(make_ins(0, 26, 0, 0, 0, 1'b0));
        ins       = make_ins(0, 27, 1, 2, 0, 1'b0);
        ins.gr_we = 1'b0;
        issue(ins);
        issue(make_ins(0, 28, 27, 0, 0, 1'b0));
        issue(make_ins(6, 0, 3, 0, 0, 1'b0));
        issue(make_ins(6, 0, 4, 0, 0, 1'b0));
        issue(make_ins(0, 29, 0, 0, 0, 1'b0));
        finish_test("zero_reg", e0);
    endtask

    task automatic random_test();
        ds_to_es_t ins;
        int        e0;
        int        k;
        e0 = errors;
        for (int i = 0; i < 8; i++) begin
            store(0, i, 'h100 + 4 * i);
        end
        for (int i = 0; i < 200; i++) begin
            k = $urandom_range(13, 0);
            if (k == 12) begin
                store(0, $urandom_range(7, 0), 'h100 + 4 * $urandom_range(7, 0));
            end else if (k == 13) begin
                load($urandom_range(7, 0), 0, 'h100 + 4 * $urandom_range(7, 0));
            end else begin
                ins = make_ins(k, $urandom_range(7, 0), $urandom_range(7, 0),
                               $urandom_range(7, 0), $urandom(), 1'b0);
                if (k == 11) begin
                    ins.src2_is_imm = 1'b1;
                end else if (k >= 8) begin
                    ins.src1_is_sa = 1'($urandom());
                end else begin
                    ins.src2_is_imm = 1'($urandom());
                end
                issue(ins);
            end
        end
        finish_test("random", e0);
    endtask

    // every test issues at most one instruction per cycle
    initial begin
        #((num_instrs + slack_cycles) * 100);
        $display("watchdog expired before the tests completed");
        $display("Test failures found");
        $finish;
    end

    initial begin
        clk            = 1'b0;
        reset          = 1'b1;
        ds_to_es_valid = 1'b0;
        ds_to_es_bus   = '0;
        cycle          = 0;
        errors         = 0;
        tests_run      = 0;
        tests_failed   = 0;
        pc_next        = 32'hbfc0_0000;
        void'($urandom(32'ha06b175d));
        for (int r = 0; r < 32; r++) begin
            arch[r]   = '0;
            shadow[r] = '0;
        end
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;
        alu_ops_test();
        chain_test();
        distance_test();
        memory_test();
        zero_reg_test();
        random_test();
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
